// ==== common/rv_macros.svh ====
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// data word width
`define XLEN 32

// integer register count, x0 included
`define NREGS 32

// first fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

// ==== common/rv_pkg.sv ====
package rv_pkg;

    // alu operations, pass_b serves lui
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b
    } alu_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    // branch offset is scattered, bit 0 is implied
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one instruction word, seen through each encoding format
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } inst_u;

    typedef struct packed {
        logic reg_write;
        logic mem_write;
        logic mem_read;
        logic alu_src;
        alu_t alu_ctrl;
        logic is_branch;
        logic is_jal;
        logic is_jalr;
        logic lui;
        logic auipc;
    } ctrl_t;

endpackage

// ==== common/mem_req_if.sv ====
`include "rv_macros.svh"

// one data memory request from the MW stage
interface mem_req_if;
    logic             req;
    logic             write;
    logic [`XLEN-1:0] addr;
    logic [`XLEN-1:0] wdata;
    logic [`XLEN-1:0] rdata;
    // single cycle pulse, transfer finished
    logic             done;

    modport core (
        output req,
        output write,
        output addr,
        output wdata,
        input  rdata,
        input  done
    );

    modport bus (
        input  req,
        input  write,
        input  addr,
        input  wdata,
        output rdata,
        output done
    );
endinterface

// ==== data_path/alu.sv ====
`include "rv_macros.svh"

module alu
    import rv_pkg::*;
(
    input  logic [`XLEN-1:0] a,
    input  logic [`XLEN-1:0] b,
    input  alu_t             op,
    input  logic [2:0]       funct3,
    output logic [`XLEN-1:0] result,
    output logic             cond
);

    logic lt_s;
    logic lt_u;

    // both comparisons are shared by slt and the branch check
    assign lt_s = $signed(a) < $signed(b);
    assign lt_u = a < b;

    always_comb begin
        case (op)
            alu_add:    result = a + b;
            alu_sub:    result = a - b;
            alu_sll:    result = a << b[4:0];
            alu_slt:    result = {{(`XLEN-1){1'b0}}, lt_s};
            alu_sltu:   result = {{(`XLEN-1){1'b0}}, lt_u};
            alu_xor:    result = a ^ b;
            alu_srl:    result = a >> b[4:0];
            alu_sra:    result = $signed(a) >>> b[4:0];
            alu_or:     result = a | b;
            alu_and:    result = a & b;
            alu_pass_b: result = b;
            default:    result = '0;
        endcase
    end

    // branch condition, funct3 as in the branch encoding
    always_comb begin
        case (funct3)
            3'b000:  cond = a == b;
            3'b001:  cond = a != b;
            3'b100:  cond = lt_s;
            3'b101:  cond = !lt_s;
            3'b110:  cond = lt_u;
            3'b111:  cond = !lt_u;
            default: cond = 1'b0;
        endcase
    end

endmodule

// ==== data_path/data_path.sv ====
`include "rv_macros.svh"

module data_path
    import rv_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    output logic [`XLEN-1:0] current_pc,
    input  logic [`XLEN-1:0] inst,
    input  ctrl_t            ctrl,
    input  logic             forward_a,
    input  logic             forward_b,
    input  logic             pc_en,
    input  logic             if_ex_en,
    input  logic             if_ex_clr,
    input  logic             ex_mw_clr,
    output inst_u            inst_ex,
    output logic [4:0]       rs1_ex,
    output logic [4:0]       rs2_ex,
    output logic [4:0]       rd_mw,
    output logic             reg_write_mw,
    output logic             mem_read_mw,
    output logic             branch_taken,
    mem_req_if.core          mem
);

    logic [`XLEN-1:0] pc_ex;
    logic [`XLEN-1:0] rf [`NREGS];
    logic [`XLEN-1:0] rs1_val;
    logic [`XLEN-1:0] rs2_val;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] alu_result;
    logic             cond;
    logic [`XLEN-1:0] target_base;
    logic [`XLEN-1:0] target_sum;
    logic [`XLEN-1:0] target;
    logic [`XLEN-1:0] link_addr;
    logic [`XLEN-1:0] ex_result;
    logic             mem_write_mw;
    logic [`XLEN-1:0] result_mw;
    logic [`XLEN-1:0] store_mw;
    logic [`XLEN-1:0] wb_data;
    logic             mw_hold;
    logic             rf_we;

    // IF stage
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            current_pc <= `RESET_PC;
        end else if (pc_en) begin
            current_pc <= branch_taken ? target : current_pc + `XLEN'd4;
        end
    end

    // IF/EX register, a cleared word decodes as a bubble
    always_ff @(posedge clk) begin
        if (!rst_n || if_ex_clr) begin
            inst_ex <= '0;
        end else if (if_ex_en) begin
            inst_ex <= inst;
        end
    end

    always_ff @(posedge clk) begin
        if (if_ex_en) begin
            pc_ex <= current_pc;
        end
    end

    // EX stage
    assign rs1_ex = inst_ex.r_fmt.rs1;
    assign rs2_ex = inst_ex.r_fmt.rs2;

    // x0 reads zero, MW result bypasses the register file
    assign rs1_val = forward_a ? wb_data : (rs1_ex == '0 ? '0 : rf[rs1_ex]);
    assign rs2_val = forward_b ? wb_data : (rs2_ex == '0 ? '0 : rf[rs2_ex]);

    always_comb begin
        if (ctrl.lui || ctrl.auipc) begin
            imm = {inst_ex.u_fmt.imm, 12'b0};
        end else if (ctrl.is_jal) begin
            imm = {{12{inst_ex.j_fmt.imm20}}, inst_ex.j_fmt.imm19_12,
                   inst_ex.j_fmt.imm11, inst_ex.j_fmt.imm10_1, 1'b0};
        end else if (ctrl.is_branch) begin
            imm = {{20{inst_ex.b_fmt.imm12}}, inst_ex.b_fmt.imm11,
                   inst_ex.b_fmt.imm10_5, inst_ex.b_fmt.imm4_1, 1'b0};
        end else if (ctrl.mem_write) begin
            imm = {{20{inst_ex.s_fmt.imm_hi[6]}}, inst_ex.s_fmt.imm_hi, inst_ex.s_fmt.imm_lo};
        end else begin
            imm = {{20{inst_ex.i_fmt.imm[11]}}, inst_ex.i_fmt.imm};
        end
    end

    assign op_a = ctrl.auipc ? pc_ex : rs1_val;
    assign op_b = ctrl.alu_src ? imm : rs2_val;

    alu alu_inst (
        .a      (op_a),
        .b      (op_b),
        .op     (ctrl.alu_ctrl),
        .funct3 (inst_ex.r_fmt.funct3),
        .result (alu_result),
        .cond   (cond)
    );

    // jalr drops bit 0 of its target
    assign target_base = ctrl.is_jalr ? rs1_val : pc_ex;
    assign target_sum  = target_base + imm;
    assign target      = {target_sum[`XLEN-1:1], target_sum[0] & ~ctrl.is_jalr};

    assign branch_taken = (ctrl.is_branch && cond) || ctrl.is_jal || ctrl.is_jalr;
    assign link_addr    = pc_ex + `XLEN'd4;
    assign ex_result    = (ctrl.is_jal || ctrl.is_jalr) ? link_addr : alu_result;

    // EX/MW register, frozen while the bus transfer is open
    assign mw_hold = mem.req && !mem.done;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            reg_write_mw <= 1'b0;
            mem_write_mw <= 1'b0;
            mem_read_mw  <= 1'b0;
        end else if (!mw_hold) begin
            if (ex_mw_clr) begin
                reg_write_mw <= 1'b0;
                mem_write_mw <= 1'b0;
                mem_read_mw  <= 1'b0;
            end else begin
                reg_write_mw <= ctrl.reg_write;
                mem_write_mw <= ctrl.mem_write;
                mem_read_mw  <= ctrl.mem_read;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!mw_hold) begin
            rd_mw     <= inst_ex.r_fmt.rd;
            result_mw <= ex_result;
            store_mw  <= rs2_val;
        end
    end

    // MW stage
    assign mem.req   = mem_read_mw || mem_write_mw;
    assign mem.write = mem_write_mw;
    assign mem.addr  = result_mw;
    assign mem.wdata = store_mw;

    assign wb_data = mem_read_mw ? mem.rdata : result_mw;
    assign rf_we   = reg_write_mw && !mw_hold && rd_mw != '0;

    always_ff @(posedge clk) begin
        if (rf_we) begin
            rf[rd_mw] <= wb_data;
        end
    end

    a_ld_st_excl: assert property (@(posedge clk) disable iff (!rst_n)
        ctrl.mem_read |-> !ctrl.mem_write);

    // a redirect always leaves a bubble behind it
    a_redirect_bubble: assert property (@(posedge clk) disable iff (!rst_n)
        (branch_taken && pc_en) |=> inst_ex.r_fmt.opcode == 7'b0);

endmodule

// ==== control_unit/control_unit.sv ====
module control_unit
    import rv_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  inst_u      inst_ex,
    input  logic [4:0] rs1_ex,
    input  logic [4:0] rs2_ex,
    input  logic [4:0] rd_mw,
    input  logic       reg_write_mw,
    input  logic       mem_read_mw,
    input  logic       branch_taken,
    input  logic       mem_busy,
    output ctrl_t      ctrl,
    output logic       forward_a,
    output logic       forward_b,
    output logic       pc_en,
    output logic       if_ex_en,
    output logic       if_ex_clr,
    output logic       ex_mw_clr
);

    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;

    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       alt_ok;
    logic       load_use;
    logic       stall;

    function automatic alu_t alu_decode(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return alt ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    assign funct3 = inst_ex.r_fmt.funct3;
    assign funct7 = inst_ex.r_fmt.funct7;

    // funct7 may only be zero, or 0100000 for sub and sra
    assign alt_ok = funct7 == 7'b0 ||
                    (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));

    // anything not matched stays all zero and runs as a no-op
    always_comb begin
        ctrl = '0;
        case (inst_ex.r_fmt.opcode)
            op_reg: begin
                ctrl.reg_write = alt_ok;
                ctrl.alu_ctrl  = alu_decode(funct3, funct7[5]);
            end
            op_imm: begin
                ctrl.reg_write = funct3[1:0] != 2'b01 || alt_ok;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_ctrl  = alu_decode(funct3, funct3 == 3'b101 && funct7[5]);
            end
            op_lui: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_ctrl  = alu_pass_b;
                ctrl.lui       = 1'b1;
            end
            op_auipc: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_ctrl  = alu_add;
                ctrl.auipc     = 1'b1;
            end
            op_load: begin
                ctrl.reg_write = funct3 == 3'b010;
                ctrl.mem_read  = funct3 == 3'b010;
                ctrl.alu_src   = 1'b1;
            end
            op_store: begin
                ctrl.mem_write = funct3 == 3'b010;
                ctrl.alu_src   = 1'b1;
            end
            op_branch: ctrl.is_branch = funct3[2:1] != 2'b01;
            op_jal: begin
                ctrl.reg_write = 1'b1;
                ctrl.is_jal    = 1'b1;
            end
            op_jalr: begin
                ctrl.reg_write = funct3 == 3'b000;
                ctrl.is_jalr   = funct3 == 3'b000;
            end
            default: ;
        endcase
    end

    // bypass from MW when a source matches a nonzero rd
    assign forward_a = reg_write_mw && rd_mw != '0 && rd_mw == rs1_ex;
    assign forward_b = reg_write_mw && rd_mw != '0 && rd_mw == rs2_ex;

    assign load_use = mem_read_mw && rd_mw != '0 && (rd_mw == rs1_ex || rd_mw == rs2_ex);
    assign stall    = mem_busy || load_use;

    assign pc_en     = !stall;
    assign if_ex_en  = !stall;
    assign if_ex_clr = branch_taken && !stall;
    // the load leaves MW and a bubble takes its place while EX waits
    assign ex_mw_clr = load_use && !mem_busy;

    // a stalled EX instruction is neither flushed nor replaced
    a_no_flush_in_stall: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> $stable(inst_ex));

    // once the load has gone, the dependent op no longer sees a load in MW
    a_load_use_drains: assert property (@(posedge clk) disable iff (!rst_n)
        ex_mw_clr |=> !mem_read_mw);

endmodule

// ==== source/apb_mem_master.sv ====
`include "rv_macros.svh"

module apb_mem_master (
    input  logic             clk,
    input  logic             rst_n,
    mem_req_if.bus           mem,
    output logic             mem_busy,
    output logic [`XLEN-1:0] paddr,
    output logic             psel,
    output logic             penable,
    output logic             pwrite,
    output logic [`XLEN-1:0] pwdata,
    input  logic [`XLEN-1:0] prdata,
    input  logic             pready
);

    localparam logic [1:0] idle   = 2'd0;
    localparam logic [1:0] setup  = 2'd1;
    localparam logic [1:0] access = 2'd2;

    logic [1:0] state;
    logic       write_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= idle;
        end else begin
            case (state)
                idle:    if (mem.req) state <= setup;
                setup:   state <= access;
                access:  if (pready) state <= idle;
                default: state <= idle;
            endcase
        end
    end

    // request captured when accepted, MW holds it anyway until done
    always_ff @(posedge clk) begin
        if (state == idle && mem.req) begin
            paddr   <= mem.addr;
            pwdata  <= mem.wdata;
            write_q <= mem.write;
        end
    end

    assign psel    = state != idle;
    assign penable = state == access;
    assign pwrite  = psel && write_q;

    assign mem.done  = penable && pready;
    assign mem.rdata = prdata;
    // busy from the first MW cycle up to, not including, the pready cycle
    assign mem_busy  = mem.req && !mem.done;

    a_apb_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (penable && !pready) |=> $stable(paddr) && $stable(pwdata) && $stable(pwrite) &&
                                 $stable(psel) && $stable(penable));

endmodule

// ==== source/rv32_core.sv ====
`include "rv_macros.svh"

module rv32_core
    import rv_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,

    // instruction fetch
    output logic [`XLEN-1:0] current_pc,
    input  logic [`XLEN-1:0] inst,

    // apb data memory
    output logic [`XLEN-1:0] paddr,
    output logic             psel,
    output logic             penable,
    output logic             pwrite,
    output logic [`XLEN-1:0] pwdata,
    input  logic [`XLEN-1:0] prdata,
    input  logic             pready
);

    // control unit to data path
    ctrl_t      ctrl;
    logic       forward_a;
    logic       forward_b;
    logic       pc_en;
    logic       if_ex_en;
    logic       if_ex_clr;
    logic       ex_mw_clr;

    // data path to control unit
    inst_u      inst_ex;
    logic [4:0] rs1_ex;
    logic [4:0] rs2_ex;
    logic [4:0] rd_mw;
    logic       reg_write_mw;
    logic       mem_read_mw;
    logic       branch_taken;

    // apb master to control unit
    logic       mem_busy;

    mem_req_if mem ();

    data_path data_path_inst (
        .*
    );

    control_unit controller_inst (
        .*
    );

    apb_mem_master apb_master_inst (
        .*
    );

endmodule

// ==== dv/tb_apb_mem.sv ====
`include "rv_macros.svh"

// instruction ROM on the fetch port and APB data memory with wait states
module tb_apb_mem (
    input  logic             clk,
    input  logic [`XLEN-1:0] current_pc,
    output logic [`XLEN-1:0] inst,
    input  logic [`XLEN-1:0] paddr,
    input  logic             psel,
    input  logic             penable,
    input  logic             pwrite,
    input  logic [`XLEN-1:0] pwdata,
    output logic [`XLEN-1:0] prdata,
    output logic             pready
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [`XLEN-1:0] rom [256];
    logic [`XLEN-1:0] ram [256];
    logic             rand_wait = 1'b0;
    int               seed = 21;
    int               wait_left;

    // fetch is combinational, word indexed
    assign inst = rom[current_pc[9:2]];

    // every word of the data memory starts with a value of its own
    function automatic logic [`XLEN-1:0] fill_word(input logic [7:0] idx);
        return {idx, ~idx, idx ^ 8'h5a, 8'hc3 - idx} ^ 32'h6b3c_a591;
    endfunction

    task automatic init_mem();
        for (int i = 0; i < 256; i++) begin
            rom[i] = 32'h0000_0013;
            ram[i] = fill_word(i[7:0]);
        end
    endtask

    initial begin
        pready = 1'b0;
        prdata = '0;
    end

    // slave responses change shortly after the rising edge
    always @(posedge clk) begin
        #2;
        if (psel && !penable) begin
            wait_left = rand_wait ? $unsigned($random(seed)) % 4 : 0;
            pready = 1'b0;
        end else if (psel && penable && wait_left > 0) begin
            wait_left--;
            pready = 1'b0;
        end else if (psel && penable) begin
            pready = 1'b1;
            if (pwrite) begin
                ram[paddr[9:2]] = pwdata;
            end else begin
                prdata = ram[paddr[9:2]];
            end
        end else begin
            pready = 1'b0;
        end
    end

endmodule

// ==== dv/tb_rv32_core.sv ====
`include "rv_macros.svh"

module tb_rv32_core;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;

    // every program ends with a store here
    localparam logic [`XLEN-1:0] sentinel_addr = 32'h0000_03fc;

    logic             clk;
    logic             rst_n;
    logic [`XLEN-1:0] current_pc;
    logic [`XLEN-1:0] inst;
    logic [`XLEN-1:0] paddr;
    logic             psel;
    logic             penable;
    logic             pwrite;
    logic [`XLEN-1:0] pwdata;
    logic [`XLEN-1:0] prdata;
    logic             pready;

    logic [`XLEN-1:0] exp_addr [$];
    logic [`XLEN-1:0] exp_data [$];
    logic [`XLEN-1:0] ea;
    logic [`XLEN-1:0] ed;
    logic [`XLEN-1:0] st_addr;
    string            names [3] = '{"alu", "load-use", "control flow"};
    int               n_words;
    int               errors;
    int               n_tests;
    int               n_failed;
    int               n_stores;
    int               cycles;
    int               cycle_limit;
    bit               sentinel_seen;

    rv32_core i_dut (.*);

    tb_apb_mem i_mem (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, op_reg};
    endfunction

    function automatic logic [31:0] enc_i(input logic [31:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm[11:0], rs1, f3, rd, op};
    endfunction

    // word store, rs2 is the data
    function automatic logic [31:0] enc_s(input logic [31:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], op_store};
    endfunction

    function automatic logic [31:0] enc_b(input logic [31:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
    endfunction

    function automatic logic [31:0] enc_u(input logic [31:0] imm, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm[31:12], rd, op};
    endfunction

    function automatic logic [31:0] enc_j(input logic [31:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
    endfunction

    task automatic put(input logic [31:0] w);
        i_mem.rom[n_words] = w;
        n_words++;
    endtask

    // result slots are consecutive words from 0x100
    task automatic store_reg(input logic [4:0] rs);
        put(enc_s(st_addr, rs, 5'd0));
        st_addr += 4;
    endtask

    // a branch that, when taken, jumps over one store
    task automatic branch_over_store(input logic [2:0] f3, input logic [4:0] rs1,
                                     input logic [4:0] rs2);
        put(enc_b(32'd8, rs2, rs1, f3));
        store_reg(rs1);
    endtask

    task automatic build_program(input int prog);
        i_mem.init_mem();
        n_words = 0;
        st_addr = 32'h100;
        case (prog)
            0: begin
                // each op reads the result of the one before it
                put(enc_u(32'h12345000, 1, op_lui));
                put(enc_i(32'h678, 1, 3'd0, 1, op_imm));
                put(enc_i(-1, 1, 3'd4, 2, op_imm));
                put(enc_r(7'h00, 2, 1, 3'd0, 3));
                put(enc_r(7'h20, 1, 3, 3'd0, 4));
                put(enc_r(7'h00, 1, 4, 3'd1, 5));
                put(enc_r(7'h00, 4, 5, 3'd2, 6));
                put(enc_r(7'h00, 6, 4, 3'd3, 7));
                put(enc_r(7'h00, 2, 7, 3'd4, 8));
                put(enc_r(7'h00, 8, 2, 3'd5, 9));
                put(enc_r(7'h20, 9, 2, 3'd5, 10));
                put(enc_r(7'h00, 1, 10, 3'd6, 11));
                put(enc_r(7'h00, 2, 11, 3'd7, 12));
                put(enc_i(-3, 12, 3'd2, 13, op_imm));
                put(enc_i(-3, 13, 3'd3, 14, op_imm));
                put(enc_i(32'h0f0, 14, 3'd6, 15, op_imm));
                put(enc_i(32'h7f3, 15, 3'd7, 16, op_imm));
                put(enc_i(7, 16, 3'd1, 17, op_imm));
                put(enc_i(3, 17, 3'd5, 18, op_imm));
                put(enc_i(32'h409, 2, 3'd5, 19, op_imm));
                put(enc_u(32'h00001000, 20, op_auipc));
                put(enc_r(7'h00, 19, 20, 3'd0, 21));
                // x0 write must be dropped, also on the bypass
                put(enc_i(5, 21, 3'd0, 0, op_imm));
                put(enc_r(7'h00, 0, 0, 3'd0, 22));
                for (int r = 0; r <= 22; r++) begin
                    store_reg(r[4:0]);
                end
            end
            1: begin
                put(enc_i(32'h123, 0, 3'd0, 1, op_imm));
                put(enc_s(32'h200, 1, 0));
                put(enc_i(32'h200, 0, 3'd2, 2, op_load));
                put(enc_r(7'h00, 1, 2, 3'd0, 3));
                store_reg(3);
                // untouched word, then its value used as store data at once
                put(enc_i(32'h208, 0, 3'd2, 4, op_load));
                store_reg(4);
                put(enc_i(32'h200, 0, 3'd2, 5, op_load));
                put(enc_i(1, 5, 3'd0, 6, op_imm));
                store_reg(6);
            end
            default: begin
                put(enc_i(-7, 0, 3'd0, 1, op_imm));
                put(enc_i(3, 0, 3'd0, 2, op_imm));
                branch_over_store(3'd0, 1, 2);
                branch_over_store(3'd1, 1, 2);
                branch_over_store(3'd4, 1, 2);
                branch_over_store(3'd5, 1, 2);
                branch_over_store(3'd4, 2, 1);
                branch_over_store(3'd5, 2, 1);
                branch_over_store(3'd0, 2, 2);
                branch_over_store(3'd1, 1, 1);
                // call, store the link, jump over the callee
                put(enc_j(32'd12, 5));
                store_reg(5);
                put(enc_j(32'd20, 0));
                put(enc_i(100, 5, 3'd0, 6, op_imm));
                store_reg(6);
                // odd return address, jalr clears bit 0
                put(enc_i(1, 5, 3'd0, 8, op_imm));
                put(enc_i(0, 8, 3'd0, 7, op_jalr));
                store_reg(7);
            end
        endcase
        put(enc_s(sentinel_addr, 5'd0, 5'd0));
        put(enc_j(32'd0, 5'd0));
    endtask

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // ISA level run of the ROM, fills the expected store list
    function automatic int ref_run();
        logic [31:0] x [32];
        logic [31:0] dmem [256];
        logic [31:0] pc, next_pc, w, a, b, res, addr;
        logic [31:0] imm_i, imm_s, imm_b, imm_j;
        logic [2:0]  f3;
        logic        wr;
        logic        taken;
        int          count;
        bit          finished;
        exp_addr.delete();
        exp_data.delete();
        for (int i = 0; i < 256; i++) begin
            dmem[i] = i_mem.fill_word(i[7:0]);
        end
        for (int i = 0; i < 32; i++) begin
            x[i] = '0;
        end
        pc = `RESET_PC;
        count = 0;
        finished = 1'b0;
        while (!finished && count < 10000) begin
            w = i_mem.rom[pc[9:2]];
            f3 = w[14:12];
            a = x[w[19:15]];
            b = x[w[24:20]];
            imm_i = {{20{w[31]}}, w[31:20]};
            imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
            imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            next_pc = pc + 4;
            res = '0;
            wr = w[6:0] inside {op_reg, op_imm, op_lui, op_auipc, op_load, op_jal, op_jalr};
            case (w[6:0])
                op_reg:   res = alu_ref(f3, w[30], a, b);
                op_imm:   res = alu_ref(f3, f3 == 3'd5 && w[30], a, imm_i);
                op_lui:   res = {w[31:12], 12'b0};
                op_auipc: res = pc + {w[31:12], 12'b0};
                op_load: begin
                    addr = a + imm_i;
                    res = dmem[addr[9:2]];
                end
                op_store: begin
                    addr = a + imm_s;
                    dmem[addr[9:2]] = b;
                    exp_addr.push_back(addr);
                    exp_data.push_back(b);
                    finished = addr == sentinel_addr;
                end
                op_branch: begin
                    case (f3)
                        3'd0: taken = a == b;
                        3'd1: taken = a != b;
                        3'd4: taken = $signed(a) < $signed(b);
                        3'd5: taken = $signed(a) >= $signed(b);
                        3'd6: taken = a < b;
                        default: taken = a >= b;
                    endcase
                    if (taken) begin
                        next_pc = pc + imm_b;
                    end
                end
                op_jal: begin
                    res = pc + 4;
                    next_pc = pc + imm_j;
                end
                op_jalr: begin
                    res = pc + 4;
                    next_pc = (a + imm_i) & ~32'd1;
                end
                default: ;
            endcase
            if (wr && w[11:7] != 5'd0) begin
                x[w[11:7]] = res;
            end
            pc = next_pc;
            count++;
        end
        return count;
    endfunction

    task automatic check_idle(input string phase);
        idle_check: assert (!psel && !penable && current_pc == `RESET_PC) else begin
            $display("FAILED at %0t: %s psel %b penable %b pc %h, expected 0 0 %h",
                     $time, phase, psel, penable, current_pc, `RESET_PC);
            errors++;
        end
    endtask

    task automatic run_test(input int prog, input bit waits);
        int err_before;
        int n_expected;
        err_before = errors;
        @(posedge clk);
        #2;
        rst_n = 1'b0;
        build_program(prog);
        void'(ref_run());
        n_expected = exp_addr.size();
        i_mem.rand_wait = waits;
        sentinel_seen = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_idle("during reset");
        @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        check_idle("after reset");
        while (!sentinel_seen) @(posedge clk);
        if (exp_addr.size() != 0) begin
            $display("%0d expected stores never appeared", exp_addr.size());
            errors++;
        end
        n_tests++;
        if (errors != err_before) begin
            n_failed++;
        end
        $display("test %0d %s, %s: %s, %0d stores", n_tests, names[prog],
                 waits ? "random wait states" : "no wait states",
                 (errors == err_before) ? "pass" : "fail", n_expected);
    endtask

    // a write completes in the cycle where pready meets penable
    always @(negedge clk) begin
        if (rst_n && psel && penable && pwrite && pready) begin
            n_stores++;
            if (exp_addr.size() == 0) begin
                $display("unexpected store of %h to %h at %0t", pwdata, paddr, $time);
                errors++;
            end else begin
                ea = exp_addr.pop_front();
                ed = exp_data.pop_front();
                store_check: assert (paddr == ea && pwdata == ed) else begin
                    $display("FAILED at %0t: store expected %h to %h, got %h to %h",
                             $time, ed, ea, pwdata, paddr);
                    errors++;
                end
            end
            if (paddr == sentinel_addr) begin
                sentinel_seen = 1'b1;
            end
        end
    end

    initial begin
        cycles = 0;
        wait (cycle_limit > 0);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, a program never reached its last store", cycles);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        int total;
        rst_n = 1'b0;
        errors = 0;
        n_tests = 0;
        n_failed = 0;
        n_stores = 0;
        total = 0;
        for (int p = 0; p < 3; p++) begin
            build_program(p);
            total += ref_run();
        end
        // six runs, each program twice, each with its own reset
        cycle_limit = 4 * (2 * total * 5) + 6 * 5;
        for (int r = 0; r < 6; r++) begin
            run_test(r % 3, r >= 3);
        end
        $display("%0d tests, %0d failed, %0d stores checked, %0d errors",
                 n_tests, n_failed, n_stores, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+common
common/rv_pkg.sv
common/mem_req_if.sv
data_path/alu.sv
data_path/data_path.sv
control_unit/control_unit.sv
source/apb_mem_master.sv
source/rv32_core.sv
dv/tb_apb_mem.sv
dv/tb_rv32_core.sv
